// File: hdl/br_types_pkg.sv
// Datapath is fixed at 4 columns x 4 lanes x 64 bits; the conf struct assumes exactly 4 lanes
package br_types_pkg;

   localparam int WORD_BITS = 64;                    // One lane
   localparam int LANES     = 4;                     // Lanes per column
   localparam int COLS      = 4;                     // Columns per bank, one per phase
   localparam int COL_BITS  = LANES * WORD_BITS;     // 256
   localparam int BANK_BITS = COLS * COL_BITS;       // 1024

   typedef logic [WORD_BITS-1:0] word_t;             // Lane word
   typedef logic [COL_BITS-1:0]  col_t;              // Lane 0 in low bits
   typedef logic [BANK_BITS-1:0] bank_t;             // Column 0 in low bits

   // Effective address, only the low 5 bits matter here
   // [4:3] memory lane, [2:0] byte offset
   typedef logic [31:0] eaddr_t;
   typedef logic [1:0]  lane_idx_t;                  // ea[4:3]
   typedef logic [2:0]  byte_ofs_t;                  // ea[2:0]

   typedef logic [1:0]  phase_t;                     // Column phase 0..3

   // Lane source select
   typedef enum logic [1:0] {
      OFF     = 2'd0,                                // Hold lane
      MEM1    = 2'd1,                                // Same lane of port 1
      TR      = 2'd2,                                // Transfer register
      SPECIAL = 2'd3                                 // Aligned / exd / off by lane
   } lane_src_e;

   // Load op for the aligned lanes, code 3 behaves as unaligned
   typedef enum logic [1:0] {
      LD_WORD      = 2'd0,                           // 32-bit half, zero-extended
      LD_BYTE      = 2'd1,                           // One byte, zero-extended
      LD_UNALIGNED = 2'd2                            // 64-bit byte-shifted
   } ld_op_e;

   // Per-phase configuration, 12 bits
   typedef struct packed {
      lane_src_e src3;
      lane_src_e src2;
      lane_src_e src1;
      lane_src_e src0;
      ld_op_e    op1;                                // Lane 1 op, uses ea1
      ld_op_e    op0;                                // Lane 0 op, uses ea0
   } br_conf_t;

endpackage

// File: hdl/br_pio_pkg.sv
// PIO writes carry whole 256-bit columns masked in 32-bit words; row field is 6 bits
package br_pio_pkg;

   localparam int ROW_BITS      = 6;                 // Address bits 12:7 on the host side
   localparam int MASK_BITS     = 8;                 // One bit per 32-bit word
   localparam int PIO_WORD_BITS = br_types_pkg::COL_BITS / MASK_BITS;   // 32

   typedef logic [ROW_BITS-1:0]  row_t;
   typedef logic [MASK_BITS-1:0] mask_t;

   // Host request payload, held stable while req is high
   typedef struct packed {
      row_t                 row;                     // Target row
      br_types_pkg::phase_t col;                     // Target column
      mask_t                mask;                    // Word enables
      br_types_pkg::col_t   data;                    // Column data
   } pio_req_t;

   // One-cycle write into both banks
   typedef struct packed {
      logic                 strobe;
      br_types_pkg::phase_t col;
      mask_t                mask;
      br_types_pkg::col_t   data;
   } bank_wr_t;

endpackage

// File: hdl/br_pio_port.sv
// Host must hold req and payload until ack; exec high stalls the write indefinitely
`timescale 1ns/100ps

module br_pio_port #(
   parameter br_pio_pkg::row_t ROW_ID = 5            // This row's number
) (
   input  logic                 ACLK,
   input  logic                 RSTN,
   input  br_pio_pkg::pio_req_t pio_req,
   input  logic                 pio_valid_req,
   input  logic                 exec,
   output logic                 pio_ack,
   output br_pio_pkg::bank_wr_t bank_wr
);
   import br_pio_pkg::*;

   typedef enum logic [1:0] {
      IDLE,                                          // Wait for req
      PEND,                                          // Payload held, wait for exec low
      WRITE,                                         // Strobe cycle
      ACK                                            // Ack high, wait for req low
   } pio_state_e;

   pio_state_e state_q;
   pio_req_t   req_q;                                // Latched payload
   logic       stb_q;                                // Write strobe
   logic       ack_q;

   // Handshake FSM
   always_ff @(posedge ACLK or negedge RSTN) begin
      if (!RSTN) begin
         state_q <= IDLE;
         stb_q   <= 1'b0;
         ack_q   <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (pio_valid_req) begin
                  state_q <= PEND;                   // Payload captured below
               end
            end
            PEND: begin
               if (!exec) begin                      // Banks free next cycle
                  stb_q   <= (req_q.row == ROW_ID);  // Foreign rows only ack
                  state_q <= WRITE;
               end
            end
            WRITE: begin
               stb_q   <= 1'b0;                      // Single pulse
               ack_q   <= 1'b1;                      // Same edge as bank write
               state_q <= ACK;
            end
            default: begin
               if (!pio_valid_req) begin
                  ack_q   <= 1'b0;
                  state_q <= IDLE;
               end
            end
         endcase
      end
   end

   // Payload register
   always_ff @(posedge ACLK) begin
      if (state_q == IDLE && pio_valid_req) begin
         req_q <= pio_req;
      end
   end

   assign pio_ack = ack_q;

   assign bank_wr = '{
      strobe: stb_q,
      col:    req_q.col,
      mask:   req_q.mask,
      data:   req_q.data
   };

endmodule

// File: hdl/br_lane_select.sv
// Purely combinational; only ea bits 4:0 are looked at, and lane 3 has no SPECIAL source
`timescale 1ns/100ps

module br_lane_select (
   input  br_types_pkg::phase_t                         phase,
   input  br_types_pkg::br_conf_t [br_types_pkg::COLS-1:0]  conf,
   input  br_types_pkg::word_t [br_types_pkg::LANES-1:0] tx,
   input  br_types_pkg::word_t                          exd,
   input  br_types_pkg::eaddr_t                         ea0,
   input  br_types_pkg::eaddr_t                         ea1,
   input  br_types_pkg::word_t [br_types_pkg::LANES-1:0] mr0,
   input  br_types_pkg::word_t [br_types_pkg::LANES-1:0] mr1,
   output br_types_pkg::col_t                           lane_data,
   output logic [br_types_pkg::LANES-1:0]               lane_en
);
   import br_types_pkg::*;

   localparam int HALF_BITS = WORD_BITS / 2;

   br_conf_t  cfg;                                   // Config of current phase
   lane_idx_t idx0, idx1;                            // Memory lane picks
   byte_ofs_t ofs0, ofs1;                            // Byte offsets
   word_t     m0, m1;                                // Selected memory words
   word_t     al0, al1;                              // Aligned load results
   lane_src_e src  [LANES];
   word_t     spec [LANES];                          // SPECIAL source per lane

   // Load alignment
   // din is shifted down by ofs bytes, fill supplies the vacated top bytes
   function automatic word_t align(input ld_op_e op, input byte_ofs_t ofs,
                                   input word_t din, input word_t fill);
      logic [2*WORD_BITS-1:0] pair;
      word_t                  res;
      pair = {fill, din} >> {ofs, 3'b000};
      case (op)
         LD_WORD: begin
            res = {{HALF_BITS{1'b0}},
                   (ofs[2] ? din[HALF_BITS +: HALF_BITS] : din[0 +: HALF_BITS])};
         end
         LD_BYTE: begin
            res = {{(WORD_BITS-8){1'b0}}, pair[7:0]};  // Byte ofs after shift
         end
         default: begin
            res = pair[WORD_BITS-1:0];               // Unaligned
         end
      endcase
      return res;
   endfunction

   assign cfg  = conf[phase];
   assign idx0 = ea0[4:3];
   assign idx1 = ea1[4:3];
   assign ofs0 = ea0[2:0];
   assign ofs1 = ea1[2:0];
   assign m0   = mr0[idx0];
   assign m1   = mr1[idx1];

   assign al0 = align(cfg.op0, ofs0, m0, m1);        // Top bytes from m1
   assign al1 = align(cfg.op1, ofs1, m1, '0);        // Zero fill

   assign src[0] = cfg.src0;
   assign src[1] = cfg.src1;
   assign src[2] = cfg.src2;
   assign src[3] = cfg.src3;

   assign spec[0] = al0;
   assign spec[1] = al1;
   assign spec[2] = exd;
   assign spec[3] = '0;                              // Never enabled

   // Lane muxes and enables
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         case (src[i])
            MEM1:    lane_data[i*WORD_BITS +: WORD_BITS] = mr1[i];
            TR:      lane_data[i*WORD_BITS +: WORD_BITS] = tx[i];
            SPECIAL: lane_data[i*WORD_BITS +: WORD_BITS] = spec[i];
            default: lane_data[i*WORD_BITS +: WORD_BITS] = '0;     // OFF, masked
         endcase
         lane_en[i] = (src[i] != OFF);
      end
      if (src[LANES-1] == SPECIAL) begin
         lane_en[LANES-1] = 1'b0;                    // Lane 3 SPECIAL acts as OFF
      end
   end

endmodule

// File: hdl/br_bank_regs.sv
// PIO strobe and exec are assumed never to coincide; if they do, the PIO write wins
`timescale 1ns/100ps

module br_bank_regs (
   input  logic                                 ACLK,
   input  logic                                 RSTN,
   input  br_pio_pkg::bank_wr_t                 bank_wr,
   input  br_types_pkg::col_t                   lane_data,
   input  logic [br_types_pkg::LANES-1:0]       lane_en,
   input  logic                                 exec,
   input  logic                                 stream_valid,
   output br_types_pkg::phase_t                 phase,
   output br_types_pkg::bank_t                  bout,
   output logic                                 bout_valid
);
   import br_types_pkg::*;
   import br_pio_pkg::*;

   phase_t            phase_q;
   logic              bsel_q;                        // 0 front active, 1 back active
   col_t [COLS-1:0]   bank_q [2];                    // [0] front, [1] back
   logic              valid_q;

   phase_t            wr_col;                        // Column to update
   col_t              wr_bits;                       // Bit enables
   col_t              wr_data;
   logic [1:0]        wr_hit;                        // Per-bank write enable

   // Phase counter, bank select, output valid
   always_ff @(posedge ACLK or negedge RSTN) begin
      if (!RSTN) begin
         phase_q <= '0;
         bsel_q  <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         phase_q <= phase_q + 2'd1;                  // Free-running wrap
         if (phase_q == 2'd3) begin
            bsel_q  <= ~bsel_q;                      // Swap after last column
            valid_q <= stream_valid;
         end
      end
   end

   // Write source merge
   always_comb begin
      wr_col  = phase_q;
      wr_bits = '0;
      wr_data = lane_data;
      wr_hit  = 2'b00;
      if (bank_wr.strobe) begin
         wr_col  = bank_wr.col;
         wr_data = bank_wr.data;
         wr_hit  = 2'b11;                            // Host writes both banks
         for (int w = 0; w < MASK_BITS; w++) begin
            wr_bits[w*PIO_WORD_BITS +: PIO_WORD_BITS] = {PIO_WORD_BITS{bank_wr.mask[w]}};
         end
      end else if (exec) begin
         wr_hit[~bsel_q] = 1'b1;                     // Inactive bank only
         for (int l = 0; l < LANES; l++) begin
            wr_bits[l*WORD_BITS +: WORD_BITS] = {WORD_BITS{lane_en[l]}};
         end
      end
   end

   // Bank storage
   always_ff @(posedge ACLK or negedge RSTN) begin
      if (!RSTN) begin
         bank_q[0] <= '0;
         bank_q[1] <= '0;
      end else begin
         for (int b = 0; b < 2; b++) begin
            if (wr_hit[b]) begin
               bank_q[b][wr_col] <= (bank_q[b][wr_col] & ~wr_bits) | (wr_data & wr_bits);
            end
         end
      end
   end

   assign phase      = phase_q;
   assign bout       = bank_q[bsel_q];               // Active bank
   assign bout_valid = valid_q;

endmodule

// File: hdl/br_top.sv
// One array row; ROW_ID must match the host's row field for PIO writes to land
`timescale 1ns/100ps

module br_top #(
   parameter br_pio_pkg::row_t ROW_ID = 5
) (
   input  logic                                          ACLK,
   input  logic                                          RSTN,
   input  br_pio_pkg::pio_req_t                          pio_req,
   input  logic                                          pio_valid_req,
   output logic                                          pio_ack,
   input  logic                                          exec,
   input  br_types_pkg::br_conf_t [br_types_pkg::COLS-1:0] conf,
   input  br_types_pkg::word_t [br_types_pkg::LANES-1:0]  tx,
   input  br_types_pkg::word_t                           exd,
   input  br_types_pkg::eaddr_t                          ea0,
   input  br_types_pkg::eaddr_t                          ea1,
   input  br_types_pkg::word_t [br_types_pkg::LANES-1:0]  mr0,
   input  br_types_pkg::word_t [br_types_pkg::LANES-1:0]  mr1,
   input  logic                                          stream_valid,
   output br_types_pkg::bank_t                           bout,
   output logic                                          bout_valid
);
   import br_types_pkg::*;
   import br_pio_pkg::*;

   bank_wr_t          bank_wr;                       // PIO to banks
   phase_t            phase;                         // Banks to selector
   col_t              lane_data;                     // Selector to banks
   logic [LANES-1:0]  lane_en;

   br_pio_port #(
      .ROW_ID        (ROW_ID)
   ) u_pio_port (
      .ACLK          (ACLK),
      .RSTN          (RSTN),
      .pio_req       (pio_req),
      .pio_valid_req (pio_valid_req),
      .exec          (exec),
      .pio_ack       (pio_ack),
      .bank_wr       (bank_wr)
   );

   br_lane_select u_lane_select (
      .phase         (phase),
      .conf          (conf),
      .tx            (tx),
      .exd           (exd),
      .ea0           (ea0),
      .ea1           (ea1),
      .mr0           (mr0),
      .mr1           (mr1),
      .lane_data     (lane_data),
      .lane_en       (lane_en)
   );

   br_bank_regs u_bank_regs (
      .ACLK          (ACLK),
      .RSTN          (RSTN),
      .bank_wr       (bank_wr),
      .lane_data     (lane_data),
      .lane_en       (lane_en),
      .exec          (exec),
      .stream_valid  (stream_valid),
      .phase         (phase),
      .bout          (bout),
      .bout_valid    (bout_valid)
   );

endmodule

// File: sim/br_asserts.sv
// Bound into every br_pio_port; the fail count is read by the testbench top
`timescale 1ns/100ps

module br_asserts (
   input logic                 ACLK,
   input logic                 RSTN,
   input br_pio_pkg::pio_req_t pio_req,
   input logic                 pio_valid_req,
   input logic                 pio_ack
);
   int fails;                                           // Failed assertion count

   ack_needs_req: assert property (@(posedge ACLK) disable iff (!RSTN)
      $rose(pio_ack) |-> $past(pio_valid_req))
      else begin
         $error("pio_ack rose with no request pending");
         fails++;
      end

   ack_after_req: assert property (@(posedge ACLK) disable iff (!RSTN)
      $fell(pio_ack) |-> !$past(pio_valid_req))
      else begin
         $error("pio_ack fell while req was still high");
         fails++;
      end

   payload_hold: assert property (@(posedge ACLK) disable iff (!RSTN)
      (pio_valid_req && $past(pio_valid_req)) |-> $stable(pio_req))
      else begin
         $error("PIO payload changed while req was high");
         fails++;
      end

endmodule

bind br_pio_port br_asserts u_asserts (
   .ACLK          (ACLK),
   .RSTN          (RSTN),
   .pio_req       (pio_req),
   .pio_valid_req (pio_valid_req),
   .pio_ack       (pio_ack)
);

// File: sim/br_checker.sv
// Model samples inputs at rising edges and compares outputs at falling edges; op code 3 unused
`timescale 1ns/100ps

module br_checker #(
   parameter br_pio_pkg::row_t ROW_ID = 5
) (
   input  logic                                           ACLK,
   input  logic                                           RSTN,
   input  br_pio_pkg::pio_req_t                           pio_req,
   input  logic                                           pio_valid_req,
   input  logic                                           pio_ack,
   input  logic                                           exec,
   input  logic                                           stream_valid,
   input  logic                                           bout_valid,
   input  br_types_pkg::br_conf_t [br_types_pkg::COLS-1:0] conf,
   input  br_types_pkg::word_t [br_types_pkg::LANES-1:0]   tx, mr0, mr1,
   input  br_types_pkg::word_t                            exd,
   input  br_types_pkg::eaddr_t                           ea0, ea1,
   input  br_types_pkg::bank_t                            bout,
   output int                                             errors
);
   import br_types_pkg::*;
   import br_pio_pkg::*;

   phase_t          ph;
   logic            bsel;                               // 1 shows the back bank
   logic            vld;
   col_t [COLS-1:0] bank [2];
   int              pio_st;                             // 0 idle, 1 wait exec, 2 write, 3 ack
   pio_req_t        pio_q;
   logic            ack_exp;

   // Byte-wise load alignment, hi feeds bytes past the top of w
   function automatic word_t load_align(input ld_op_e op, input logic [2:0] b,
                                        input word_t w, input word_t hi);
      logic [127:0] pair;
      word_t        r;
      pair = {hi, w};
      r    = '0;
      case (op)
         LD_WORD: r[31:0] = b[2] ? w[63:32] : w[31:0];
         LD_BYTE: r[7:0] = w[8*b +: 8];
         default: begin
            for (int k = 0; k < 8; k++) begin
               r[8*k +: 8] = pair[8*(k+b) +: 8];
            end
         end
      endcase
      return r;
   endfunction

   always @(posedge ACLK or negedge RSTN) begin : model
      br_conf_t  c;
      word_t     m0, m1, v;
      lane_src_e s;
      logic      en;
      logic      pio_wr;
      if (!RSTN) begin
         ph      = '0;
         bsel    = 1'b0;
         vld     = 1'b0;
         ack_exp = 1'b0;
         pio_st  = 0;
         bank[0] = '0;
         bank[1] = '0;
      end else begin
         pio_wr = 1'b0;
         case (pio_st)
            0: if (pio_valid_req) begin
               pio_q  = pio_req;
               pio_st = 1;
            end
            1: if (!exec) pio_st = 2;                   // Exec stalls the write
            2: begin
               pio_wr  = 1'b1;
               ack_exp = 1'b1;
               pio_st  = 3;
            end
            default: if (!pio_valid_req) begin
               ack_exp = 1'b0;
               pio_st  = 0;
            end
         endcase
         if (pio_wr && pio_q.row == ROW_ID) begin
            for (int b = 0; b < 2; b++) begin
               for (int w = 0; w < 8; w++) begin
                  if (pio_q.mask[w]) bank[b][pio_q.col][w*32 +: 32] = pio_q.data[w*32 +: 32];
               end
            end
         end else if (exec) begin
            c  = conf[ph];
            m0 = mr0[ea0[4:3]];
            m1 = mr1[ea1[4:3]];
            for (int i = 0; i < LANES; i++) begin
               case (i)
                  0: s = c.src0;
                  1: s = c.src1;
                  2: s = c.src2;
                  default: s = c.src3;
               endcase
               en = 1'b1;
               v  = '0;
               case (s)
                  MEM1: v = mr1[i];
                  TR: v = tx[i];
                  SPECIAL: begin
                     if (i == 0) v = load_align(c.op0, ea0[2:0], m0, m1);
                     else if (i == 1) v = load_align(c.op1, ea1[2:0], m1, '0);
                     else if (i == 2) v = exd;
                     else en = 1'b0;                    // Lane 3 has no special source
                  end
                  default: en = 1'b0;
               endcase
               if (en) bank[!bsel][ph][i*WORD_BITS +: WORD_BITS] = v;
            end
         end
         if (ph == 2'd3) begin
            bsel = ~bsel;
            vld  = stream_valid;
         end
         ph = ph + 2'd1;
      end
   end

   always @(negedge ACLK) begin : compare
      bank_t exp;
      int    bad;
      if (RSTN) begin
         exp = bank[bsel];
         bad = -1;
         for (int k = COLS - 1; k >= 0; k--) begin
            if (bout[k*COL_BITS +: COL_BITS] !== exp[k*COL_BITS +: COL_BITS]) bad = k;
         end
         if (bad >= 0) begin
            errors++;
            $display("mismatch at %0t ns: bout column %0d differs from model bank %0d",
                     $time, bad, bsel);
         end
         if (bout_valid !== vld) begin
            errors++;
            $display("mismatch at %0t ns: bout_valid is %b, expected %b", $time, bout_valid, vld);
         end
         if (pio_ack !== ack_exp) begin
            errors++;
            $display("mismatch at %0t ns: pio_ack is %b, expected %b", $time, pio_ack, ack_exp);
         end
      end
   end

endmodule

// File: sim/tb_top.sv
// Fixed seed 27; the watchdog limit is the sum of the per-test cycle budgets below
`timescale 1ns/100ps

module tb_top;
   import br_types_pkg::*;
   import br_pio_pkg::*;

   localparam row_t ROW_ID    = 6'd5;
   localparam int   DRIVE_DLY = 1;                      // ns after the rising edge
   localparam int   ACK_WAIT  = 64;                     // Cycles before a PIO wait gives up
   localparam int   BUDGET    = 5 + 200 + 80 + 80 + 40 + 40 + 56;   // Reset plus tests 1..6
   localparam int   MARGIN    = 100;

   logic                  ACLK = 1'b0;
   logic                  RSTN;
   pio_req_t              pio_req;
   logic                  pio_valid_req;
   logic                  pio_ack;
   logic                  exec;
   logic                  stream_valid;
   logic                  bout_valid;
   br_conf_t [COLS-1:0]   conf;
   word_t    [LANES-1:0]  tx, mr0, mr1;
   word_t                 exd;
   eaddr_t                ea0, ea1;
   bank_t                 bout;
   int                    chk_errors;                   // From the checker
   int                    tb_errors;                    // Handshake timeouts, stall violations
   int                    n_tests;

   br_top #(.ROW_ID(ROW_ID)) DUT (.*);

   br_checker #(.ROW_ID(ROW_ID)) u_checker (.*, .errors(chk_errors));

   always #5 ACLK = ~ACLK;                              // 10 ns period

   // All failure sources together
   function automatic int errs();
      return chk_errors + tb_errors + DUT.u_pio_port.u_asserts.fails;
   endfunction

   task automatic step();
      @(posedge ACLK);
      #(DRIVE_DLY);
   endtask

   function automatic col_t rand_col();
      col_t c;
      for (int w = 0; w < 8; w++) begin
         c[w*32 +: 32] = $urandom();
      end
      return c;
   endfunction

   task automatic rand_data();
      for (int i = 0; i < LANES; i++) begin
         tx[i]  = {$urandom(), $urandom()};
         mr0[i] = {$urandom(), $urandom()};
         mr1[i] = {$urandom(), $urandom()};
      end
      exd = {$urandom(), $urandom()};
      ea0 = $urandom();                                 // Low 5 bits pick lane and offset
      ea1 = $urandom();
   endtask

   // Lanes 0 and 1 forced to aligned loads when special is set
   task automatic rand_conf(input bit special);
      for (int p = 0; p < COLS; p++) begin
         conf[p].src0 = special ? SPECIAL : lane_src_e'(2'($urandom_range(0, 2)));
         conf[p].src1 = special ? SPECIAL : lane_src_e'(2'($urandom_range(0, 2)));
         conf[p].src2 = lane_src_e'(2'($urandom()));    // SPECIAL here is exd
         conf[p].src3 = lane_src_e'(2'($urandom()));    // SPECIAL here holds
         conf[p].op0  = ld_op_e'(2'($urandom_range(0, 2)));
         conf[p].op1  = ld_op_e'(2'($urandom_range(0, 2)));
      end
   endtask

   task automatic pio_write(input row_t row, input phase_t col, input mask_t mask,
                            input col_t data);
      int n;
      pio_req.row   = row;
      pio_req.col   = col;
      pio_req.mask  = mask;
      pio_req.data  = data;
      pio_valid_req = 1'b1;
      n = 0;
      while (!pio_ack && n < ACK_WAIT) begin
         step();
         n++;
      end
      if (!pio_ack) begin
         tb_errors++;
         $display("PIO request at %0t ns got no ack within %0d cycles", $time, ACK_WAIT);
      end
      pio_valid_req = 1'b0;
      n = 0;
      while (pio_ack && n < ACK_WAIT) begin
         step();
         n++;
      end
      if (pio_ack) begin
         tb_errors++;
         $display("PIO ack still high %0d cycles after req fell", ACK_WAIT);
      end
   endtask

   task automatic exec_burst(input bit special, input int cycles, input int idle);
      rand_conf(special);
      exec = 1'b1;
      repeat (cycles) begin
         rand_data();
         step();
      end
      exec = 1'b0;
      repeat (idle) step();                             // Two swaps show both banks
   endtask

   task automatic report(input string name, input int base);
      n_tests++;
      $display("test %0d %s: %0d errors", n_tests, name, errs() - base);
   endtask

   initial begin
      int base;
      int total;
      void'($urandom(27));
      RSTN          = 1'b0;
      pio_req       = '0;
      pio_valid_req = 1'b0;
      exec          = 1'b0;
      stream_valid  = 1'b0;
      conf          = '0;
      tx            = '0;
      mr0           = '0;
      mr1           = '0;
      exd           = '0;
      ea0           = '0;
      ea1           = '0;
      repeat (5) @(posedge ACLK);
      #(DRIVE_DLY) RSTN = 1'b1;

      base = errs();
      repeat (20) begin
         pio_write($urandom_range(0, 1) ? ROW_ID : 6'($urandom()), 2'($urandom()),
                   8'($urandom()), rand_col());
      end
      repeat (8) step();
      report("pio writes", base);

      base = errs();
      repeat (3) exec_burst(1'b0, 16, 8);
      report("exec bursts", base);

      base = errs();
      repeat (3) exec_burst(1'b1, 16, 8);
      report("aligned loads", base);

      base = errs();
      repeat (4) exec_burst(1'b0, 4, 4);                // Bursts straddle the swap
      report("bank swap", base);

      base = errs();
      rand_conf(1'b0);
      exec = 1'b1;
      fork
         pio_write(ROW_ID, 2'($urandom()), 8'hff, rand_col());
         begin
            repeat (12) begin
               rand_data();
               step();
               if (pio_ack) begin
                  tb_errors++;
                  $display("PIO ack at %0t ns arrived while exec was held high", $time);
               end
            end
            exec = 1'b0;                                // Releases the pending write
         end
      join
      repeat (8) step();
      report("pio under exec", base);

      base = errs();
      repeat (48) begin
         stream_valid = 1'($urandom());
         step();
      end
      stream_valid = 1'b0;
      step();
      report("stream valid", base);

      total = errs();
      $display("Totals: %0d tests run, %0d errors", n_tests, total);
      if (total == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #((BUDGET + MARGIN) * 10);
      $display("Timeout: run did not finish within %0d cycles", BUDGET + MARGIN);
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: verilog.f
hdl/br_types_pkg.sv
hdl/br_pio_pkg.sv
hdl/br_pio_port.sv
hdl/br_lane_select.sv
hdl/br_bank_regs.sv
hdl/br_top.sv
sim/br_asserts.sv
sim/br_checker.sv
sim/tb_top.sv

// File: run_sim.sh
#!/bin/bash
# Build tb_top with Verilator, run into sim.log, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_top -f verilog.f -Mdir obj_dir \
   && ./obj_dir/Vtb_top +verilator+error+limit+1000 > sim.log 2>&1 \
   || { echo "FAIL: build or simulation run did not complete"; exit 1; }
grep -q "Some tests failed" sim.log && { echo "FAIL: see sim.log"; exit 1; }
grep -q "All tests passed" sim.log || { echo "FAIL: no pass line in sim.log"; exit 1; }
echo "PASS"
